// ==== common/csr_config.svh ====
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// Data and counter widths
`define CSR_XLEN              32
`define CSR_CNT_W             64
`define CSR_ADDR_W            12

// Counters and timers, user read-only
`define CSR_ADDR_CYCLE        12'hc00
`define CSR_ADDR_TIME         12'hc01
`define CSR_ADDR_CYCLEH       12'hc80
`define CSR_ADDR_TIMEH        12'hc81

// Machine information registers, all read as zero
`define CSR_ADDR_MVENDORID    12'hf11
`define CSR_ADDR_MARCHID      12'hf12
`define CSR_ADDR_MIMPID       12'hf13
`define CSR_ADDR_MHARTID      12'hf14
`define CSR_ADDR_MCONFIGPTR   12'hf15

// Machine trap setup
`define CSR_ADDR_MSTATUS      12'h300
`define CSR_ADDR_MISA         12'h301
`define CSR_ADDR_MEDELEG      12'h302
`define CSR_ADDR_MIDELEG      12'h303
`define CSR_ADDR_MIE          12'h304
`define CSR_ADDR_MTVEC        12'h305
`define CSR_ADDR_MSTATUSH     12'h310

// Machine trap handling
`define CSR_ADDR_MSCRATCH     12'h340
`define CSR_ADDR_MEPC         12'h341
`define CSR_ADDR_MCAUSE       12'h342
`define CSR_ADDR_MTVAL        12'h343
`define CSR_ADDR_MIP          12'h344

// Address used for a squashed command
`define CSR_ADDR_NONE         12'hfff

`define MCAUSE_M_TIMER_INT    32'h8000_0007
`define MCAUSE_ECALL_BASE     32'd8

// Clock cycles per mtime tick, must be at least 1
`define CSR_TIME_DIV          4

// Memory-mapped timer register select
`define TIMER_SEL_MTIME_LO    2'd0
`define TIMER_SEL_MTIME_HI    2'd1
`define TIMER_SEL_MTIMECMP_LO 2'd2
`define TIMER_SEL_MTIMECMP_HI 2'd3

`endif

// ==== common/csr_pkg.sv ====
package csr_pkg;

    // Command presented by decode to the CSR stage
    typedef enum logic [2:0] {
        CSR_X     = 3'd0,
        CSR_W     = 3'd1,
        CSR_S     = 3'd2,
        CSR_C     = 3'd3,
        CSR_ECALL = 3'd4,
        CSR_MRET  = 3'd5,
        CSR_SRET  = 3'd6
    } csr_cmd_e;

    // Privilege levels; the hypervisor encoding 2'b10 is not implemented
    typedef enum logic [1:0] {
        MODE_USER       = 2'b00,
        MODE_SUPERVISOR = 2'b01,
        MODE_MACHINE    = 2'b11
    } priv_mode_e;

endpackage

// ==== csr/csr_stage.sv ====
`timescale 1ns/10ps
`include "csr_config.svh"

module csr_stage
    import csr_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`CSR_CNT_W-1:0] cycle,
    input  logic [`CSR_CNT_W-1:0] mtime,
    input  logic [`CSR_CNT_W-1:0] mtimecmp,
    input  logic                  wb_branch_hazard,
    input  csr_cmd_e              csr_cmd,
    input  logic [`CSR_XLEN-1:0]  op1_data,
    input  logic [`CSR_XLEN-1:0]  imm_i,
    input  logic                  interrupt_ready,
    input  logic [`CSR_XLEN-1:0]  if_pc,
    output csr_cmd_e              csr_cmd_out,
    output logic [`CSR_XLEN-1:0]  csr_rdata,
    output logic [`CSR_XLEN-1:0]  trap_vector,
    output logic                  stall_may_interrupt
);

    priv_mode_e mode;

    // mstatus fields
    logic       mstatus_sd;
    logic       mstatus_tsr;
    logic       mstatus_tw;
    logic       mstatus_tvm;
    logic       mstatus_mxr;
    logic       mstatus_sum;
    logic       mstatus_mprv;
    logic [1:0] mstatus_xs;
    logic [1:0] mstatus_fs;
    priv_mode_e mstatus_mpp;
    logic [1:0] mstatus_vs;
    logic       mstatus_spp;
    logic       mstatus_mpie;
    logic       mstatus_ube;
    logic       mstatus_spie;
    logic       mstatus_mie;
    logic       mstatus_sie;
    logic       mstatush_mbe;
    logic       mstatush_sbe;

    logic [`CSR_XLEN-1:0] medeleg;
    logic                 mideleg_mtie;

    // mie fields
    logic mie_meie;
    logic mie_seie;
    logic mie_mtie;
    logic mie_stie;
    logic mie_msie;
    logic mie_ssie;

    logic [`CSR_XLEN-1:0] mtvec;
    logic [`CSR_XLEN-1:0] mscratch;
    logic [`CSR_XLEN-1:0] mepc;
    logic [`CSR_XLEN-1:0] mcause;
    logic [`CSR_XLEN-1:0] mtval;
    logic [`CSR_XLEN-1:0] mip;

    // Command held for the write half of the access
    csr_cmd_e              save_cmd;
    logic [`CSR_ADDR_W-1:0] save_addr;
    logic [`CSR_XLEN-1:0]  save_op1;

    csr_cmd_e              cmd_eff;
    logic [`CSR_ADDR_W-1:0] addr;
    logic [`CSR_XLEN-1:0]  mstatus_rd;
    logic [`CSR_XLEN-1:0]  mie_rd;
    logic [`CSR_XLEN-1:0]  rdata_next;
    logic [`CSR_XLEN-1:0]  wdata;
    logic                  csr_write;
    logic                  timer_pending;
    logic                  trap_taken;

    // A flush squashes the command and reads the zero address
    assign cmd_eff = wb_branch_hazard ? CSR_X : csr_cmd;
    assign addr    = wb_branch_hazard ? `CSR_ADDR_NONE : imm_i[`CSR_ADDR_W-1:0];

    assign mstatus_rd = {mstatus_sd, 8'b0, mstatus_tsr, mstatus_tw, mstatus_tvm,
                         mstatus_mxr, mstatus_sum, mstatus_mprv, mstatus_xs,
                         mstatus_fs, mstatus_mpp, mstatus_vs, mstatus_spp,
                         mstatus_mpie, mstatus_ube, mstatus_spie, 1'b0,
                         mstatus_mie, 1'b0, mstatus_sie, 1'b0};

    assign mie_rd = {20'b0, mie_meie, 1'b0, mie_seie, 1'b0, mie_mtie, 1'b0,
                     mie_stie, 1'b0, mie_msie, 1'b0, mie_ssie, 1'b0};

    // Machine timer interrupt, taken in M unless delegated to S
    assign timer_pending = (mtime >= mtimecmp) && mie_mtie &&
                           ((mode == MODE_MACHINE && !mideleg_mtie && mstatus_mie) ||
                            (mode == MODE_SUPERVISOR && mideleg_mtie && mstatus_sie));

    assign stall_may_interrupt = timer_pending;
    assign trap_taken          = timer_pending && interrupt_ready;

    always_comb begin
        case (addr)
            `CSR_ADDR_CYCLE:      rdata_next = cycle[31:0];
            `CSR_ADDR_CYCLEH:     rdata_next = cycle[63:32];
            `CSR_ADDR_TIME:       rdata_next = mtime[31:0];
            `CSR_ADDR_TIMEH:      rdata_next = mtime[63:32];
            `CSR_ADDR_MSTATUS:    rdata_next = mstatus_rd;
            `CSR_ADDR_MSTATUSH:   rdata_next = {26'b0, mstatush_mbe, mstatush_sbe, 4'b0};
            `CSR_ADDR_MEDELEG:    rdata_next = medeleg;
            `CSR_ADDR_MIDELEG:    rdata_next = {24'b0, mideleg_mtie, 7'b0};
            `CSR_ADDR_MIE:        rdata_next = mie_rd;
            `CSR_ADDR_MTVEC:      rdata_next = mtvec;
            `CSR_ADDR_MSCRATCH:   rdata_next = mscratch;
            `CSR_ADDR_MEPC:       rdata_next = mepc;
            `CSR_ADDR_MCAUSE:     rdata_next = mcause;
            `CSR_ADDR_MTVAL:      rdata_next = mtval;
            `CSR_ADDR_MIP:        rdata_next = mip;
            // Information registers and misa
            `CSR_ADDR_MVENDORID, `CSR_ADDR_MARCHID, `CSR_ADDR_MIMPID,
            `CSR_ADDR_MHARTID, `CSR_ADDR_MCONFIGPTR, `CSR_ADDR_MISA,
            `CSR_ADDR_NONE:       rdata_next = '0;
            default:              rdata_next = '0;
        endcase
    end

    // Write data from the old value registered last cycle
    always_comb begin
        case (save_cmd)
            CSR_W:   wdata = save_op1;
            CSR_S:   wdata = csr_rdata | save_op1;
            CSR_C:   wdata = csr_rdata & ~save_op1;
            default: wdata = '0;
        endcase
    end

    assign csr_write = (save_cmd == CSR_W) || (save_cmd == CSR_S) || (save_cmd == CSR_C);

    always_ff @(posedge clk) begin
        save_addr <= addr;
        save_op1  <= op1_data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mode         <= MODE_MACHINE;
            csr_cmd_out  <= CSR_X;
            csr_rdata    <= '0;
            trap_vector  <= '0;
            save_cmd     <= CSR_X;
            mstatus_sd   <= 1'b0;
            mstatus_tsr  <= 1'b0;
            mstatus_tw   <= 1'b0;
            mstatus_tvm  <= 1'b0;
            mstatus_mxr  <= 1'b0;
            mstatus_sum  <= 1'b0;
            mstatus_mprv <= 1'b0;
            mstatus_xs   <= 2'b0;
            mstatus_fs   <= 2'b0;
            mstatus_mpp  <= MODE_MACHINE;
            mstatus_vs   <= 2'b0;
            mstatus_spp  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_ube  <= 1'b0;
            mstatus_spie <= 1'b0;
            mstatus_mie  <= 1'b0;
            mstatus_sie  <= 1'b0;
            mstatush_mbe <= 1'b0;
            mstatush_sbe <= 1'b0;
            medeleg      <= '0;
            mideleg_mtie <= 1'b0;
            mie_meie     <= 1'b0;
            mie_seie     <= 1'b0;
            mie_mtie     <= 1'b0;
            mie_stie     <= 1'b0;
            mie_msie     <= 1'b0;
            mie_ssie     <= 1'b0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause       <= '0;
            mtval        <= '0;
            mip          <= '0;
        end else begin
            csr_rdata <= rdata_next;
            // The command of a trap cycle is dropped
            save_cmd  <= trap_taken ? CSR_X : cmd_eff;

            if (csr_write) begin
                case (save_addr)
                    `CSR_ADDR_MSTATUS: begin
                        mstatus_sd   <= wdata[31];
                        mstatus_tsr  <= wdata[22];
                        mstatus_tw   <= wdata[21];
                        mstatus_tvm  <= wdata[20];
                        mstatus_mxr  <= wdata[19];
                        mstatus_sum  <= wdata[18];
                        mstatus_mprv <= wdata[17];
                        mstatus_xs   <= wdata[16:15];
                        mstatus_fs   <= wdata[14:13];
                        // MPP keeps its value on the reserved encoding
                        if (wdata[12:11] != 2'b10) begin
                            mstatus_mpp <= priv_mode_e'(wdata[12:11]);
                        end
                        mstatus_vs   <= wdata[10:9];
                        mstatus_spp  <= wdata[8];
                        mstatus_mpie <= wdata[7];
                        mstatus_ube  <= wdata[6];
                        mstatus_spie <= wdata[5];
                        mstatus_mie  <= wdata[3];
                        mstatus_sie  <= wdata[1];
                    end
                    `CSR_ADDR_MSTATUSH: begin
                        mstatush_mbe <= wdata[5];
                        mstatush_sbe <= wdata[4];
                    end
                    `CSR_ADDR_MEDELEG:  medeleg      <= wdata;
                    `CSR_ADDR_MIDELEG:  mideleg_mtie <= wdata[7];
                    `CSR_ADDR_MIE: begin
                        mie_meie <= wdata[11];
                        mie_seie <= wdata[9];
                        mie_mtie <= wdata[7];
                        mie_stie <= wdata[5];
                        mie_msie <= wdata[3];
                        mie_ssie <= wdata[1];
                    end
                    `CSR_ADDR_MTVEC:    mtvec    <= wdata;
                    `CSR_ADDR_MSCRATCH: mscratch <= wdata;
                    `CSR_ADDR_MEPC:     mepc     <= wdata;
                    `CSR_ADDR_MCAUSE:   mcause   <= wdata;
                    `CSR_ADDR_MTVAL:    mtval    <= wdata;
                    `CSR_ADDR_MIP:      mip      <= wdata;
                    default: begin
                    end
                endcase
            end

            // Trap and return updates come last and win over a pending write
            if (trap_taken) begin
                csr_cmd_out <= CSR_ECALL;
                trap_vector <= mtvec;
                mcause      <= `MCAUSE_M_TIMER_INT;
                if (!mideleg_mtie) begin
                    mode         <= MODE_MACHINE;
                    mstatus_mpp  <= mode;
                    mstatus_mpie <= mstatus_mie;
                    mstatus_mie  <= 1'b0;
                    mepc         <= if_pc;
                end else begin
                    mode         <= MODE_SUPERVISOR;
                    mstatus_spp  <= mode[0];
                    mstatus_spie <= mstatus_sie;
                    mstatus_sie  <= 1'b0;
                end
            end else begin
                csr_cmd_out <= cmd_eff;
                case (cmd_eff)
                    CSR_ECALL: begin
                        trap_vector <= mtvec;
                        mcause      <= `MCAUSE_ECALL_BASE + {30'b0, mode};
                        mode        <= MODE_MACHINE;
                    end
                    CSR_MRET: begin
                        trap_vector <= mepc;
                        mode        <= mstatus_mpp;
                        mstatus_mpp <= MODE_USER;
                        mstatus_mie <= mstatus_mpie;
                        if (mstatus_mpp != MODE_MACHINE) begin
                            mstatus_mprv <= 1'b0;
                        end
                    end
                    // sret is a no-op
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

// ==== csr/csr_top.sv ====
`timescale 1ns/10ps
`include "csr_config.svh"

module csr_top
    import csr_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,

    // Pipeline side
    input  csr_cmd_e             csr_cmd,
    input  logic [`CSR_XLEN-1:0] op1_data,
    input  logic [`CSR_XLEN-1:0] imm_i,
    input  logic                 wb_branch_hazard,
    input  logic                 interrupt_ready,
    input  logic [`CSR_XLEN-1:0] if_pc,
    output csr_cmd_e             csr_cmd_out,
    output logic [`CSR_XLEN-1:0] csr_rdata,
    output logic [`CSR_XLEN-1:0] trap_vector,
    output logic                 stall_may_interrupt,

    // Memory-mapped timer write strobe
    input  logic                 timer_wr_en,
    input  logic [1:0]           timer_wr_sel,
    input  logic [`CSR_XLEN-1:0] timer_wr_data
);

    logic [`CSR_CNT_W-1:0] cycle;
    logic [`CSR_CNT_W-1:0] mtime;
    logic [`CSR_CNT_W-1:0] mtimecmp;

    csr_counters i_csr_counters (
        .clk           (clk),
        .rst_n         (rst_n),
        .timer_wr_en   (timer_wr_en),
        .timer_wr_sel  (timer_wr_sel),
        .timer_wr_data (timer_wr_data),
        .cycle         (cycle),
        .mtime         (mtime),
        .mtimecmp      (mtimecmp)
    );

    csr_stage i_csr_stage (
        .clk                 (clk),
        .rst_n               (rst_n),
        .cycle               (cycle),
        .mtime               (mtime),
        .mtimecmp            (mtimecmp),
        .wb_branch_hazard    (wb_branch_hazard),
        .csr_cmd             (csr_cmd),
        .op1_data            (op1_data),
        .imm_i               (imm_i),
        .interrupt_ready     (interrupt_ready),
        .if_pc               (if_pc),
        .csr_cmd_out         (csr_cmd_out),
        .csr_rdata           (csr_rdata),
        .trap_vector         (trap_vector),
        .stall_may_interrupt (stall_may_interrupt)
    );

endmodule

// ==== hdl/csr_counters.sv ====
`timescale 1ns/10ps
`include "csr_config.svh"

module csr_counters (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  timer_wr_en,
    input  logic [1:0]            timer_wr_sel,
    input  logic [`CSR_XLEN-1:0]  timer_wr_data,
    output logic [`CSR_CNT_W-1:0] cycle,
    output logic [`CSR_CNT_W-1:0] mtime,
    output logic [`CSR_CNT_W-1:0] mtimecmp
);

    // Wide enough to hold CSR_TIME_DIV - 1, also for a divider of 1
    localparam int DIV_W = $clog2(`CSR_TIME_DIV + 1);

    logic [DIV_W-1:0] div_cnt;
    logic             tick;
    logic             wr_mtime_lo;
    logic             wr_mtime_hi;
    logic             wr_cmp_lo;
    logic             wr_cmp_hi;

    assign tick = (div_cnt == DIV_W'(`CSR_TIME_DIV - 1));

    // Timer bus decode
    assign wr_mtime_lo = timer_wr_en && (timer_wr_sel == `TIMER_SEL_MTIME_LO);
    assign wr_mtime_hi = timer_wr_en && (timer_wr_sel == `TIMER_SEL_MTIME_HI);
    assign wr_cmp_lo   = timer_wr_en && (timer_wr_sel == `TIMER_SEL_MTIMECMP_LO);
    assign wr_cmp_hi   = timer_wr_en && (timer_wr_sel == `TIMER_SEL_MTIMECMP_HI);

    // Free-running cycle count
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 1'b1;
        end
    end

    // mtime with prescaler, a bus write wins over the tick
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt <= '0;
            mtime   <= '0;
        end else if (wr_mtime_lo) begin
            div_cnt <= '0;
            mtime   <= {mtime[63:32], timer_wr_data};
        end else if (wr_mtime_hi) begin
            div_cnt <= '0;
            mtime   <= {timer_wr_data, mtime[31:0]};
        end else if (tick) begin
            div_cnt <= '0;
            mtime   <= mtime + 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Compare value, all ones keeps the interrupt quiet after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtimecmp <= '1;
        end else if (wr_cmp_lo) begin
            mtimecmp <= {mtimecmp[63:32], timer_wr_data};
        end else if (wr_cmp_hi) begin
            mtimecmp <= {timer_wr_data, mtimecmp[31:0]};
        end
    end

endmodule

// ==== tb.f ====
+incdir+common
common/csr_pkg.sv
hdl/csr_counters.sv
csr/csr_stage.sv
csr/csr_top.sv
test/csr_assert.sv
test/csr_tb.sv

// ==== test/csr_assert.sv ====
`timescale 1ns/10ps
`include "csr_config.svh"

module csr_assert
    import csr_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input csr_cmd_e    csr_cmd,
    input logic [31:0] op1_data,
    input logic [31:0] imm_i,
    input logic        wb_branch_hazard,
    input logic        interrupt_ready,
    input logic        stall_may_interrupt,
    input csr_cmd_e    csr_cmd_out,
    input logic [31:0] trap_vector
);

    int          fail_count = 0;
    logic        trap_taken;
    logic        mtvec_wr;
    logic        wr_pend;
    csr_cmd_e    wr_cmd;
    logic [31:0] wr_op;
    logic [31:0] wr_old;
    logic [31:0] exp_mtvec;

    assign trap_taken = stall_may_interrupt && interrupt_ready;
    assign mtvec_wr   = !wb_branch_hazard && !trap_taken &&
                        (imm_i[11:0] == `CSR_ADDR_MTVEC) &&
                        (csr_cmd == CSR_W || csr_cmd == CSR_S || csr_cmd == CSR_C);

    // Model of mtvec from the pipeline-side commands
    // Write lands one cycle after the command that read the old value
    always @(posedge clk) begin
        if (!rst_n) begin
            wr_pend   <= 1'b0;
            exp_mtvec <= '0;
        end else begin
            wr_pend <= mtvec_wr;
            wr_cmd  <= csr_cmd;
            wr_op   <= op1_data;
            wr_old  <= exp_mtvec;
            if (wr_pend) begin
                case (wr_cmd)
                    CSR_W:   exp_mtvec <= wr_op;
                    CSR_S:   exp_mtvec <= wr_old | wr_op;
                    default: exp_mtvec <= wr_old & ~wr_op;
                endcase
            end
        end
    end

    // Registers are cleared one edge into reset
    no_stall_in_reset: assert property (@(posedge clk) !rst_n |=> !stall_may_interrupt)
        else begin
            $error("stall_may_interrupt high during reset");
            fail_count++;
        end

    flush_gives_nop: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_branch_hazard && !trap_taken) |=> (csr_cmd_out == CSR_X))
        else begin
            $error("Flushed command was not squashed to CSR_X");
            fail_count++;
        end

    trap_targets_mtvec: assert property (@(posedge clk) disable iff (!rst_n)
        trap_taken |=> (csr_cmd_out == CSR_ECALL && trap_vector == $past(exp_mtvec)))
        else begin
            $error("Timer trap did not redirect to mtvec");
            fail_count++;
        end

endmodule

// ==== test/csr_tb.sv ====
`timescale 1ns/10ps
`include "csr_config.svh"

module csr_tb
    import csr_pkg::*;
();

    localparam int          MAX_CYCLES = 600;
    localparam logic [31:0] CMP_VALUE  = 32'd12;

    logic        clk;
    logic        rst_n;
    csr_cmd_e    csr_cmd;
    logic [31:0] op1_data;
    logic [31:0] imm_i;
    logic        wb_branch_hazard;
    logic        interrupt_ready;
    logic [31:0] if_pc;
    logic        timer_wr_en;
    logic [1:0]  timer_wr_sel;
    logic [31:0] timer_wr_data;
    csr_cmd_e    csr_cmd_out;
    logic [31:0] csr_rdata;
    logic [31:0] trap_vector;
    logic        stall_may_interrupt;

    int          errors;
    int          cycle_count;
    logic [31:0] exp_mtvec;
    logic [31:0] exp_mscratch;
    logic [31:0] trap_pc;

    csr_top i_csr_top (
        .clk                 (clk),
        .rst_n               (rst_n),
        .csr_cmd             (csr_cmd),
        .op1_data            (op1_data),
        .imm_i               (imm_i),
        .wb_branch_hazard    (wb_branch_hazard),
        .interrupt_ready     (interrupt_ready),
        .if_pc               (if_pc),
        .csr_cmd_out         (csr_cmd_out),
        .csr_rdata           (csr_rdata),
        .trap_vector         (trap_vector),
        .stall_may_interrupt (stall_may_interrupt),
        .timer_wr_en         (timer_wr_en),
        .timer_wr_sel        (timer_wr_sel),
        .timer_wr_data       (timer_wr_data)
    );

    bind csr_top csr_assert i_csr_assert (
        .clk                 (clk),
        .rst_n               (rst_n),
        .csr_cmd             (csr_cmd),
        .op1_data            (op1_data),
        .imm_i               (imm_i),
        .wb_branch_hazard    (wb_branch_hazard),
        .interrupt_ready     (interrupt_ready),
        .stall_may_interrupt (stall_may_interrupt),
        .csr_cmd_out         (csr_cmd_out),
        .trap_vector         (trap_vector)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: tests still running after %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("ERR %0t %s expected %08h actual %08h", $time, name, expected, actual);
        end
    endtask

    // Command held for one cycle, result sampled mid-cycle at t+1
    task automatic issue_cmd(input csr_cmd_e cmd, input logic [11:0] addr,
                             input logic [31:0] data, input logic flush,
                             output logic [31:0] rdata);
        @(posedge clk);
        csr_cmd          <= cmd;
        imm_i            <= {20'b0, addr};
        op1_data         <= data;
        wb_branch_hazard <= flush;
        @(posedge clk);
        csr_cmd          <= CSR_X;
        wb_branch_hazard <= 1'b0;
        @(negedge clk);
        rdata = csr_rdata;
    endtask

    // Set with a zero operand, the usual CSR read
    task automatic read_csr(input logic [11:0] addr, output logic [31:0] rdata);
        issue_cmd(CSR_S, addr, 32'h0, 1'b0, rdata);
    endtask

    task automatic timer_write(input logic [1:0] sel, input logic [31:0] data);
        @(posedge clk);
        timer_wr_en   <= 1'b1;
        timer_wr_sel  <= sel;
        timer_wr_data <= data;
        @(posedge clk);
        timer_wr_en   <= 1'b0;
    endtask

    task automatic check_reset_state();
        logic [31:0] rd;
        @(negedge clk);
        compare("csr_cmd_out", 32'(CSR_X), 32'(csr_cmd_out));
        compare("stall_may_interrupt", 32'h0, 32'(stall_may_interrupt));
        read_csr(`CSR_ADDR_MSTATUS, rd);
        compare("mstatus", 32'h0000_1800, rd);
        read_csr(`CSR_ADDR_MTVEC, rd);
        compare("mtvec", 32'h0, rd);
        read_csr(`CSR_ADDR_MVENDORID, rd);
        compare("mvendorid", 32'h0, rd);
        read_csr(12'h7c0, rd);
        compare("unimplemented csr", 32'h0, rd);
    endtask

    task automatic exercise_rw_ops();
        logic [31:0] d1;
        logic [31:0] d2;
        logic [31:0] d3;
        logic [31:0] rd;
        logic [31:0] c0;
        logic [31:0] c1;
        d1 = $urandom();
        d2 = $urandom();
        d3 = $urandom();
        issue_cmd(CSR_W, `CSR_ADDR_MSCRATCH, d1, 1'b0, rd);
        compare("mscratch before write", 32'h0, rd);
        issue_cmd(CSR_S, `CSR_ADDR_MSCRATCH, d2, 1'b0, rd);
        compare("mscratch before set", d1, rd);
        issue_cmd(CSR_C, `CSR_ADDR_MSCRATCH, d3, 1'b0, rd);
        compare("mscratch before clear", d1 | d2, rd);
        exp_mscratch = (d1 | d2) & ~d3;
        read_csr(`CSR_ADDR_MSCRATCH, rd);
        compare("mscratch", exp_mscratch, rd);
        exp_mtvec = $urandom();
        issue_cmd(CSR_W, `CSR_ADDR_MTVEC, exp_mtvec, 1'b0, rd);
        read_csr(`CSR_ADDR_MTVEC, rd);
        compare("mtvec", exp_mtvec, rd);
        // Only MEIE, SEIE, MTIE, STIE, MSIE and SSIE exist in mie
        issue_cmd(CSR_W, `CSR_ADDR_MIE, d1, 1'b0, rd);
        read_csr(`CSR_ADDR_MIE, rd);
        compare("mie", d1 & 32'h0000_0aaa, rd);
        issue_cmd(CSR_W, `CSR_ADDR_MIE, 32'h0, 1'b0, rd);
        issue_cmd(CSR_W, `CSR_ADDR_MSTATUS, d2 | 32'h1800, 1'b0, rd);
        read_csr(`CSR_ADDR_MSTATUS, rd);
        compare("mstatus", (d2 | 32'h1800) & 32'h807f_ffea, rd);
        issue_cmd(CSR_W, `CSR_ADDR_MSTATUS, 32'h0000_1800, 1'b0, rd);
        // Counter keeps running through an attempted write
        read_csr(`CSR_ADDR_CYCLE, c0);
        issue_cmd(CSR_W, `CSR_ADDR_CYCLE, d3, 1'b0, rd);
        compare("cycle before write", c0 + 32'd2, rd);
        read_csr(`CSR_ADDR_CYCLE, c1);
        compare("cycle after write", c0 + 32'd4, c1);
        repeat (3) @(posedge clk);
        read_csr(`CSR_ADDR_CYCLE, rd);
        compare("cycle delta", 32'd5, rd - c1);
    endtask

    task automatic ecall_from_machine();
        logic [31:0] rd;
        issue_cmd(CSR_ECALL, 12'h000, 32'h0, 1'b0, rd);
        compare("csr_cmd_out", 32'(CSR_ECALL), 32'(csr_cmd_out));
        compare("trap_vector", exp_mtvec, trap_vector);
        read_csr(`CSR_ADDR_MCAUSE, rd);
        compare("mcause", 32'd11, rd);
    endtask

    task automatic timer_interrupt();
        logic [31:0] rd;
        int          waited;
        timer_write(`TIMER_SEL_MTIMECMP_HI, 32'h0);
        timer_write(`TIMER_SEL_MTIMECMP_LO, CMP_VALUE);
        timer_write(`TIMER_SEL_MTIME_LO, 32'h0);
        timer_write(`TIMER_SEL_MTIME_HI, 32'h0);
        issue_cmd(CSR_W, `CSR_ADDR_MIE, 32'h0000_0080, 1'b0, rd);
        issue_cmd(CSR_S, `CSR_ADDR_MSTATUS, 32'h0000_0008, 1'b0, rd);
        // MIE takes effect at the next edge
        @(negedge clk);
        compare("stall before mtimecmp", 32'h0, 32'(stall_may_interrupt));
        waited = 0;
        while (!stall_may_interrupt && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (!stall_may_interrupt) begin
            errors++;
            $display("Timer interrupt request never rose after mtime reached mtimecmp");
        end
        // mtime sits at the compare value for a full divider period
        read_csr(`CSR_ADDR_TIME, rd);
        compare("time at interrupt", CMP_VALUE, rd);
        trap_pc = $urandom() & 32'hffff_fffc;
        @(posedge clk);
        interrupt_ready <= 1'b1;
        if_pc           <= trap_pc;
        @(posedge clk);
        interrupt_ready <= 1'b0;
        @(negedge clk);
        compare("csr_cmd_out", 32'(CSR_ECALL), 32'(csr_cmd_out));
        compare("trap_vector", exp_mtvec, trap_vector);
        compare("stall after trap", 32'h0, 32'(stall_may_interrupt));
        read_csr(`CSR_ADDR_MCAUSE, rd);
        compare("mcause", `MCAUSE_M_TIMER_INT, rd);
        read_csr(`CSR_ADDR_MEPC, rd);
        compare("mepc", trap_pc, rd);
        read_csr(`CSR_ADDR_MSTATUS, rd);
        compare("mstatus MPP MPIE MIE", 32'h0000_1880, rd & 32'h0000_1888);
    endtask

    task automatic mret_after_trap();
        logic [31:0] rd;
        // Return to user mode so that the next ecall comes from U
        issue_cmd(CSR_C, `CSR_ADDR_MSTATUS, 32'h0000_1800, 1'b0, rd);
        issue_cmd(CSR_MRET, 12'h000, 32'h0, 1'b0, rd);
        compare("csr_cmd_out", 32'(CSR_MRET), 32'(csr_cmd_out));
        compare("trap_vector", trap_pc, trap_vector);
        read_csr(`CSR_ADDR_MSTATUS, rd);
        compare("mstatus MPP MIE", 32'h0000_0008, rd & 32'h0000_1808);
        compare("stall in user mode", 32'h0, 32'(stall_may_interrupt));
        issue_cmd(CSR_ECALL, 12'h000, 32'h0, 1'b0, rd);
        compare("trap_vector", exp_mtvec, trap_vector);
        read_csr(`CSR_ADDR_MCAUSE, rd);
        compare("mcause", 32'd8, rd);
        timer_write(`TIMER_SEL_MTIMECMP_HI, 32'hffff_ffff);
    endtask

    task automatic flush_write();
        logic [31:0] rd;
        issue_cmd(CSR_W, `CSR_ADDR_MSCRATCH, $urandom(), 1'b1, rd);
        compare("csr_cmd_out", 32'(CSR_X), 32'(csr_cmd_out));
        compare("csr_rdata on flush", 32'h0, rd);
        read_csr(`CSR_ADDR_MSCRATCH, rd);
        compare("mscratch", exp_mscratch, rd);
    endtask

    initial begin
        void'($urandom(63631));
        errors           = 0;
        cycle_count      = 0;
        rst_n            = 1'b0;
        csr_cmd          = CSR_X;
        op1_data         = 32'h0;
        imm_i            = 32'h0;
        wb_branch_hazard = 1'b0;
        interrupt_ready  = 1'b0;
        if_pc            = 32'h0;
        timer_wr_en      = 1'b0;
        timer_wr_sel     = 2'd0;
        timer_wr_data    = 32'h0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        check_reset_state();
        exercise_rw_ops();
        ecall_from_machine();
        timer_interrupt();
        mret_after_trap();
        flush_write();
        repeat (2) @(posedge clk);
        $display("Errors: %0d in testbench checks, %0d in assertions",
                 errors, i_csr_top.i_csr_assert.fail_count);
        if (errors == 0 && i_csr_top.i_csr_assert.fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
